// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbTop -f project.f
	out="$$(./obj_dir/VtbTop)"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== dv/tbClock.sv ====
`default_nettype none
`timescale 1ns/1ns

// free running clock plus a synchronous reset pulse
module tbClock #(
    parameter int halfPeriod  = 20, // 40 ns period
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk); // release away from the sampling edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/tbTop.sv ====
`default_nettype none
`timescale 1ns/1ns

// random and burst stimulus for instrDecoder checked by assertions
module tbTop
    import riscvIsaPkg::*;
    import decodePkg::*;
();

    localparam int randomCycles = 3000;
    localparam int burstCycles  = 40;

    logic          clk;
    logic          rst;
    logic          instrValid;
    instrWord_t    instr;
    logic          decValid;
    decodedInstr_t decoded;

    logic          prevValid; // input stage as seen one edge ago
    instrWord_t    prevInstr;
    decodedInstr_t expected;
    logic [5:0]    outEnables;

    string testName = "reset";
    int    runLength;
    int    waitCycles;
    int    hits [string]; // rule coverage keyed by case name

    string coverNames [17] = '{"op", "opImm", "sub", "sra", "badShift", "load", "loadGap",
        "store", "branch", "branchGap", "lui", "auipc", "jal", "jalr", "unknown", "idle",
        "burst"};

    opcode_t majors [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
        OPC_STORE, OPC_OPIMM, OPC_OP};

    // --------------------------------------------------
    // reference tables indexed by funct3
    // --------------------------------------------------
    dType_e loadTable [8] = '{DT_BYTE, DT_HALF, DT_WORD, DT_BYTE, DT_BYTE_U, DT_HALF_U,
        DT_BYTE, DT_BYTE};
    dType_e storeTable [8] = '{DT_BYTE, DT_HALF, DT_WORD, DT_BYTE, DT_BYTE, DT_BYTE,
        DT_BYTE, DT_BYTE};
    branchType_e branchTable [8] = '{BR_BEQ, BR_BNE, BR_BEQ, BR_BEQ, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU};
    aluOp_e aluTable [8] = '{ALU_ADD, ALU_SHIFTL, ALU_LESS_THAN_SIGNED, ALU_LESS_THAN,
        ALU_XOR, ALU_SHIFTR, ALU_OR, ALU_AND}; // 0 and 5 refined by funct7

    tbClock #(.halfPeriod(20), .resetCycles(4)) u_clock (.clk(clk), .rst(rst));

    instrDecoder u_dut (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .decValid   (decValid),
        .decoded    (decoded)
    );

    // --------------------------------------------------
    // failure reporting
    // --------------------------------------------------
    task automatic stopWithFailure();
        $display("Checks failed");
        $fatal(1, "decoder testbench stopped");
    endtask

    task automatic reportMismatch(input string checkName, input logic [31:0] expectedValue,
                                  input logic [31:0] actualValue);
        $display("FAIL %s %s expected %0h actual %0h", testName, checkName,
                 expectedValue, actualValue);
        stopWithFailure();
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        stopWithFailure();
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // flags are {regWrite, memWrite, load, jump, auipc}
    function automatic ctrlBits_t ctrlOf(input rawType_e fmt, input aluSelect_e sel,
                                         input logic [4:0] flags);
        ctrlBits_t c;
        c.rawType   = fmt;
        c.aluSelect = sel;
        {c.regWrite, c.memWrite, c.load, c.jump, c.auipc} = flags;
        return c;
    endfunction

    function automatic aluOp_e expectAluOp(input funct3_t f3, input funct7_t f7,
                                           input logic regForm);
        if (f3 == 3'd0 && regForm && f7 == 7'h20) return ALU_SUB;
        if (f3 == 3'd5 && f7 == 7'h20) return ALU_SHIFTR_ARITH;
        if ((f3 == 3'd5 || (f3 == 3'd0 && regForm)) && f7 != 7'h00) return ALU_NONE;
        return aluTable[f3];
    endfunction

    function automatic decodedInstr_t expectDecode(input instrWord_t w);
        decodedInstr_t e;
        funct3_t       f3;
        funct7_t       f7;
        f3 = w[14:12];
        f7 = w[31:25];
        e  = '0; // fmt R, nothing enabled, alu none, byte, beq
        case (w[6:0])
            OPC_LUI:    e.ctrl = ctrlOf(FMT_U, SEL_IALU, 5'b10000);
            OPC_JAL:    e.ctrl = ctrlOf(FMT_J, SEL_NONE, 5'b10010);
            OPC_AUIPC: begin
                e.ctrl  = ctrlOf(FMT_U, SEL_IALU, 5'b10001);
                e.aluOp = ALU_ADD;
            end
            OPC_JALR: begin
                e.ctrl  = ctrlOf(FMT_I, SEL_IALU, 5'b10010);
                e.aluOp = ALU_ADD;
            end
            OPC_BRANCH: begin
                e.ctrl       = ctrlOf(FMT_B, SEL_NONE, 5'b00000);
                e.branchType = branchTable[f3];
            end
            OPC_LOAD: begin
                e.ctrl  = ctrlOf(FMT_I, SEL_IALU, 5'b10100);
                e.aluOp = ALU_ADD;
                e.dType = loadTable[f3];
            end
            OPC_STORE: begin
                e.ctrl  = ctrlOf(FMT_S, SEL_IALU, 5'b01000);
                e.aluOp = ALU_ADD;
                e.dType = storeTable[f3];
            end
            OPC_OPIMM: begin
                e.ctrl  = ctrlOf(FMT_I, SEL_IALU, 5'b10000);
                e.aluOp = expectAluOp(f3, f7, 1'b0);
            end
            OPC_OP: begin
                e.ctrl  = ctrlOf(FMT_R, SEL_IALU, 5'b10000);
                e.aluOp = expectAluOp(f3, f7, 1'b1);
            end
            default: e = '0; // unknown opcode
        endcase
        return e;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            prevValid <= 1'b0;
            prevInstr <= '0;
        end else begin
            prevValid <= instrValid;
            prevInstr <= instr;
        end
    end

    always_comb expected = expectDecode(prevInstr);

    assign outEnables = {decValid, decoded.ctrl.regWrite, decoded.ctrl.memWrite,
                         decoded.ctrl.load, decoded.ctrl.jump, decoded.ctrl.auipc};

    // --------------------------------------------------
    // checking
    // --------------------------------------------------
    validTiming: assert property (@(posedge clk) disable iff (rst) decValid == prevValid)
        else reportMismatch("decValid", 32'($sampled(prevValid)), 32'($sampled(decValid)));

    idleEnables: assert property (@(posedge clk) disable iff (rst)
        !prevValid |-> outEnables == 6'd0)
        else reportMismatch("idleEnables", 32'd0, 32'($sampled(outEnables)));

    ctrlMatch: assert property (@(posedge clk) disable iff (rst)
        decValid |-> decoded.ctrl == expected.ctrl)
        else reportMismatch("ctrl", 32'($sampled(expected.ctrl)),
                            32'($sampled(decoded.ctrl)));

    aluOpMatch: assert property (@(posedge clk) disable iff (rst)
        decValid |-> decoded.aluOp == expected.aluOp)
        else reportMismatch("aluOp", 32'($sampled(expected.aluOp)),
                            32'($sampled(decoded.aluOp)));

    dTypeMatch: assert property (@(posedge clk) disable iff (rst)
        decValid |-> decoded.dType == expected.dType)
        else reportMismatch("dType", 32'($sampled(expected.dType)),
                            32'($sampled(decoded.dType)));

    branchTypeMatch: assert property (@(posedge clk) disable iff (rst)
        decValid |-> decoded.branchType == expected.branchType)
        else reportMismatch("branchType", 32'($sampled(expected.branchType)),
                            32'($sampled(decoded.branchType)));

    // --------------------------------------------------
    // coverage of the rule cases
    // --------------------------------------------------
    task automatic noteHit(input string name);
        if (hits.exists(name)) hits[name] = hits[name] + 1;
        else hits[name] = 1;
    endtask

    always @(posedge clk) begin : coverageTrack
        funct3_t f3;
        funct7_t f7;
        f3 = prevInstr[14:12];
        f7 = prevInstr[31:25];
        if (rst) begin
            runLength = 0;
        end else if (!decValid) begin
            runLength = 0;
            noteHit("idle");
        end else begin
            runLength = runLength + 1;
            if (runLength >= 32) noteHit("burst"); // long back-to-back run
            case (prevInstr[6:0])
                OPC_OP: begin
                    noteHit("op");
                    if (f3 == 3'd0 && f7 == 7'h20) noteHit("sub");
                    if (f3 == 3'd5 && f7 == 7'h20) noteHit("sra");
                    if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) noteHit("badShift");
                end
                OPC_OPIMM:  noteHit("opImm");
                OPC_LOAD: begin
                    noteHit("load");
                    if (f3 == 3'd3 || f3 > 3'd5) noteHit("loadGap");
                end
                OPC_STORE:  noteHit("store");
                OPC_BRANCH: begin
                    noteHit("branch");
                    if (f3 == 3'd2 || f3 == 3'd3) noteHit("branchGap");
                end
                OPC_LUI:    noteHit("lui");
                OPC_AUIPC:  noteHit("auipc");
                OPC_JAL:    noteHit("jal");
                OPC_JALR:   noteHit("jalr");
                default:    noteHit("unknown");
            endcase
        end
    end

    function automatic string firstMissing();
        foreach (coverNames[i]) begin
            if (!hits.exists(coverNames[i])) return coverNames[i];
        end
        return "";
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    function automatic instrWord_t randomInstr();
        logic [31:0] bits;
        logic [31:0] pick;
        opcode_t     op;
        funct7_t     f7;
        int          idx;
        bits = $urandom;
        pick = $urandom;
        idx  = int'(pick[31:16]) % 9; // near uniform over the majors
        if (pick[2:0] == 3'd0) op = bits[6:0]; // stray opcode
        else op = majors[idx];
        case (pick[9:8])
            2'd0:    f7 = 7'h00;
            2'd1:    f7 = 7'h20;
            default: f7 = bits[31:25]; // mostly illegal for shifts
        endcase
        return {f7, bits[24:15], bits[14:12], bits[11:7], op};
    endfunction

    initial begin
        void'($urandom(32'h1b7d_269e));
        instrValid = 1'b1;           // held through reset and must not leak out
        instr      = 32'h0010_0093;  // addi x1, x0, 1
        for (waitCycles = 0; waitCycles < 16 && rst !== 1'b0; waitCycles++) begin
            @(negedge clk);
        end
        if (rst !== 1'b0) abortRun("reset was never released");

        testName = "randomMix";
        repeat (randomCycles) begin
            @(negedge clk);
            instrValid = ($urandom % 8) != 0; // roughly one bubble in eight
            instr      = randomInstr();
        end

        testName = "burst";
        repeat (burstCycles) begin
            @(negedge clk);
            instrValid = 1'b1;
            instr      = randomInstr();
        end

        testName = "drain";
        @(negedge clk);
        instrValid = 1'b0;
        @(negedge clk);
        for (waitCycles = 0; waitCycles < 8 && decValid; waitCycles++) begin
            @(negedge clk);
        end
        if (decValid) abortRun("decValid stayed high after the input went idle");
        repeat (2) @(negedge clk);

        if (firstMissing() == "") begin
            $display("All checks passed");
            $finish;
        end else begin
            abortRun({"stimulus never reached the ", firstMissing(), " case"});
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/riscvIsaPkg.sv
source/decodePkg.sv
source/decodeControl.sv
source/aluOpDecoder.sv
source/memTypeDecoder.sv
source/branchTypeDecoder.sv
source/instrDecoder.sv
dv/tbClock.sv
dv/tbTop.sv

// ==== source/aluOpDecoder.sv ====
`default_nettype none
`timescale 1ns/1ns

// funct3/funct7 -> integer alu op
module aluOpDecoder
    import riscvIsaPkg::*;
    import decodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instrClass_e instrClass,
    input  funct3_t     funct3,
    input  funct7_t     funct7,
    output aluOp_e      aluOp
);

    localparam funct7_t funct7Base = 7'h00;
    localparam funct7_t funct7Alt  = 7'h20; // sub, sra

    aluOp_e aluOpNext;

    always_comb begin
        aluOpNext = ALU_NONE;
        case (instrClass)
            CLS_OPIMM, CLS_OP: begin
                case (funct3)
                    3'd0: begin
                        if (instrClass == CLS_OPIMM) begin
                            aluOpNext = ALU_ADD; // addi treats funct7 as imm bits
                        end else if (funct7 == funct7Base) begin
                            aluOpNext = ALU_ADD;
                        end else if (funct7 == funct7Alt) begin
                            aluOpNext = ALU_SUB;
                        end else begin
                            aluOpNext = ALU_NONE; // illegal funct7
                        end
                    end
                    3'd1: aluOpNext = ALU_SHIFTL;
                    3'd2: aluOpNext = ALU_LESS_THAN_SIGNED; // slt
                    3'd3: aluOpNext = ALU_LESS_THAN;        // sltu
                    3'd4: aluOpNext = ALU_XOR;
                    3'd5: begin
                        // srl and sra share funct3
                        if (funct7 == funct7Base) begin
                            aluOpNext = ALU_SHIFTR;
                        end else if (funct7 == funct7Alt) begin
                            aluOpNext = ALU_SHIFTR_ARITH;
                        end else begin
                            aluOpNext = ALU_NONE;
                        end
                    end
                    3'd6: aluOpNext = ALU_OR;
                    default: aluOpNext = ALU_AND; // 3'd7
                endcase
            end
            // address or pc arithmetic
            CLS_AUIPC, CLS_LOAD, CLS_STORE, CLS_JALR: aluOpNext = ALU_ADD;
            default: aluOpNext = ALU_NONE; // lui passes imm through
        endcase
    end

    // --------------------------------------------------
    // output register that captures every edge
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            aluOp <= ALU_NONE;
        end else begin
            aluOp <= aluOpNext;
        end
    end

endmodule

`default_nettype wire

// ==== source/branchTypeDecoder.sv ====
`default_nettype none
`timescale 1ns/1ns

// funct3 -> branch compare
module branchTypeDecoder
    import riscvIsaPkg::*;
    import decodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instrClass_e instrClass,
    input  funct3_t     funct3,
    output branchType_e branchType
);

    branchType_e branchTypeNext;

    always_comb begin
        branchTypeNext = BR_BEQ;
        if (instrClass == CLS_BRANCH) begin
            case (funct3)
                3'd1:    branchTypeNext = BR_BNE;
                3'd4:    branchTypeNext = BR_BLT;
                3'd5:    branchTypeNext = BR_BGE;
                3'd6:    branchTypeNext = BR_BLTU;
                3'd7:    branchTypeNext = BR_BGEU;
                default: branchTypeNext = BR_BEQ; // 0, and 2/3 are unused
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) branchType <= BR_BEQ;
        else     branchType <= branchTypeNext;
    end

endmodule

`default_nettype wire

// ==== source/decodeControl.sv ====
`default_nettype none
`timescale 1ns/1ns

// opcode -> class plus the registered control bits
module decodeControl
    import riscvIsaPkg::*;
    import decodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  opcode_t     opcode,
    output instrClass_e instrClass, // comb class for the datapath decoders
    output ctrlBits_t   ctrl,
    output logic        decValid
);

    // nothing enabled, format R
    localparam ctrlBits_t ctrlIdle = '{
        rawType:   FMT_R,
        aluSelect: SEL_NONE,
        regWrite:  1'b0,
        memWrite:  1'b0,
        load:      1'b0,
        jump:      1'b0,
        auipc:     1'b0
    };

    ctrlBits_t ctrlNext;

    // --------------------------------------------------
    // classify
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            OPC_LUI:    instrClass = CLS_LUI;
            OPC_AUIPC:  instrClass = CLS_AUIPC;
            OPC_JAL:    instrClass = CLS_JAL;
            OPC_JALR:   instrClass = CLS_JALR;
            OPC_BRANCH: instrClass = CLS_BRANCH;
            OPC_LOAD:   instrClass = CLS_LOAD;
            OPC_STORE:  instrClass = CLS_STORE;
            OPC_OPIMM:  instrClass = CLS_OPIMM;
            OPC_OP:     instrClass = CLS_OP;
            default:    instrClass = CLS_NONE; // anything else is a bubble
        endcase
    end

    // --------------------------------------------------
    // control bits per class
    // --------------------------------------------------
    always_comb begin
        ctrlNext = ctrlIdle;
        case (instrClass)
            CLS_LUI: begin
                ctrlNext.rawType   = FMT_U;
                ctrlNext.aluSelect = SEL_IALU;
                ctrlNext.regWrite  = 1'b1;
            end
            CLS_AUIPC: begin
                ctrlNext.rawType   = FMT_U;
                ctrlNext.aluSelect = SEL_IALU;
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.auipc     = 1'b1; // pc + imm
            end
            CLS_OPIMM: begin
                ctrlNext.rawType   = FMT_I;
                ctrlNext.aluSelect = SEL_IALU;
                ctrlNext.regWrite  = 1'b1;
            end
            CLS_OP: begin
                ctrlNext.rawType   = FMT_R;
                ctrlNext.aluSelect = SEL_IALU;
                ctrlNext.regWrite  = 1'b1;
            end
            CLS_LOAD: begin
                ctrlNext.rawType   = FMT_I;
                ctrlNext.aluSelect = SEL_IALU; // address add
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.load      = 1'b1;
            end
            CLS_STORE: begin
                ctrlNext.rawType   = FMT_S;
                ctrlNext.aluSelect = SEL_IALU;
                ctrlNext.memWrite  = 1'b1; // no rd
            end
            CLS_BRANCH: begin
                ctrlNext.rawType = FMT_B; // compare lives in the branch unit
            end
            CLS_JAL: begin
                ctrlNext.rawType  = FMT_J;
                ctrlNext.regWrite = 1'b1; // link
                ctrlNext.jump     = 1'b1;
            end
            CLS_JALR: begin
                ctrlNext.rawType   = FMT_I;
                ctrlNext.aluSelect = SEL_IALU; // rs1 + imm target
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.jump      = 1'b1;
            end
            default: ctrlNext = ctrlIdle;
        endcase
    end

    // --------------------------------------------------
    // pipeline register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl     <= ctrlIdle;
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid;
            ctrl     <= instrValid ? ctrlNext : ctrlIdle; // no strobe means no enables
        end
    end

endmodule

`default_nettype wire

// ==== source/decodePkg.sv ====
`default_nettype none

`include "decode_defines.svh"

// what the decoder hands to the rest of the core
package decodePkg;

    // --------------------------------------------------
    // alu operation
    // --------------------------------------------------
    typedef enum logic [`ALUOP_W-1:0] {
        ALU_NONE             = 0,
        ALU_SHIFTL           = 1,
        ALU_SHIFTR           = 2,
        ALU_SHIFTR_ARITH     = 3,
        ALU_ADD              = 4, // also address calc and auipc
        ALU_SUB              = 5,
        ALU_AND              = 6,
        ALU_OR               = 7,
        ALU_XOR              = 8,
        ALU_LESS_THAN        = 9, // sltu
        ALU_LESS_THAN_SIGNED = 10 // slt
        // 11..18 kept free for mul/div/rem
    } aluOp_e;

    // which execution unit owns the result
    typedef enum logic [1:0] {
        SEL_NONE = 0, // branch, jal
        SEL_IALU = 1
    } aluSelect_e;

    // immediate format, drives the imm generator
    typedef enum logic [2:0] {
        FMT_R = 0,
        FMT_I = 1,
        FMT_S = 2,
        FMT_B = 3,
        FMT_U = 4,
        FMT_J = 5
    } rawType_e;

    // lsu access size and sign
    typedef enum logic [2:0] {
        DT_BYTE   = 0,
        DT_HALF   = 1,
        DT_WORD   = 2,
        DT_BYTE_U = 3,
        DT_HALF_U = 4
    } dType_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 0,
        BR_BNE  = 1,
        BR_BLT  = 2,
        BR_BGE  = 3,
        BR_BLTU = 4,
        BR_BGEU = 5
    } branchType_e;

    // --------------------------------------------------
    // internal class per major opcode
    // --------------------------------------------------
    typedef enum logic [3:0] {
        CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
        CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_OPIMM, CLS_OP
    } instrClass_e;

    // --------------------------------------------------
    // decoded bundle
    // --------------------------------------------------
    typedef struct packed {
        rawType_e   rawType;
        aluSelect_e aluSelect;
        logic       regWrite; // rd write
        logic       memWrite; // lsu store
        logic       load;     // rd from lsu instead of alu
        logic       jump;     // pc mux, rd gets pc+4
        logic       auipc;    // alu operand a is pc
    } ctrlBits_t;

    typedef struct packed {
        ctrlBits_t   ctrl;
        aluOp_e      aluOp;
        dType_e      dType;
        branchType_e branchType;
    } decodedInstr_t;

endpackage

`default_nettype wire

// ==== source/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// --------------------------------------------------
// instruction word
// --------------------------------------------------
`define XLEN 32 // rv32 word

// --------------------------------------------------
// field positions and widths
// --------------------------------------------------
`define OPCODE_LSB 0
`define OPCODE_W 7

`define FUNCT3_LSB 12
`define FUNCT3_W 3

`define FUNCT7_LSB 25 // top seven bits
`define FUNCT7_W 7

// --------------------------------------------------
// decoder output widths
// --------------------------------------------------
// room for the M ops as well, even though only
// the base integer set is decoded here
`define ALUOP_W 5

`endif

// ==== source/instrDecoder.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "decode_defines.svh"

// rv32i decoder top with one cycle of latency
module instrDecoder
    import riscvIsaPkg::*;
    import decodePkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          instrValid,
    input  instrWord_t    instr,
    output logic          decValid,
    output decodedInstr_t decoded
);

    // --------------------------------------------------
    // field split
    // --------------------------------------------------
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = instr[`OPCODE_LSB +: `OPCODE_W];
    assign funct3 = instr[`FUNCT3_LSB +: `FUNCT3_W];
    assign funct7 = instr[`FUNCT7_LSB +: `FUNCT7_W];

    instrClass_e instrClass; // shared by all three field decoders
    ctrlBits_t   ctrl;
    aluOp_e      aluOp;
    dType_e      dType;
    branchType_e branchType;

    // --------------------------------------------------
    // decoders
    // --------------------------------------------------
    decodeControl u_control (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .opcode     (opcode),
        .instrClass (instrClass),
        .ctrl       (ctrl),
        .decValid   (decValid)
    );

    aluOpDecoder u_aluOp (
        .clk(clk), .rst(rst), .instrClass(instrClass),
        .funct3(funct3), .funct7(funct7), .aluOp(aluOp)
    );

    memTypeDecoder u_memType (
        .clk(clk), .rst(rst), .instrClass(instrClass),
        .funct3(funct3), .dType(dType)
    );

    branchTypeDecoder u_branchType (
        .clk(clk), .rst(rst), .instrClass(instrClass),
        .funct3(funct3), .branchType(branchType)
    );

    // all four parts were registered on the same edge
    assign decoded = '{ctrl: ctrl, aluOp: aluOp, dType: dType, branchType: branchType};

endmodule

`default_nettype wire

// ==== source/memTypeDecoder.sv ====
`default_nettype none
`timescale 1ns/1ns

// funct3 -> lsu access type
module memTypeDecoder
    import riscvIsaPkg::*;
    import decodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instrClass_e instrClass,
    input  funct3_t     funct3,
    output dType_e      dType
);

    dType_e dTypeNext;

    always_comb begin
        dTypeNext = DT_BYTE;
        if (instrClass == CLS_LOAD) begin
            case (funct3)
                3'd1:    dTypeNext = DT_HALF;
                3'd2:    dTypeNext = DT_WORD;
                3'd4:    dTypeNext = DT_BYTE_U; // lbu
                3'd5:    dTypeNext = DT_HALF_U; // lhu
                default: dTypeNext = DT_BYTE;   // lb and unused codes
            endcase
        end else if (instrClass == CLS_STORE) begin
            case (funct3)
                3'd1:    dTypeNext = DT_HALF;
                3'd2:    dTypeNext = DT_WORD;
                default: dTypeNext = DT_BYTE; // no unsigned stores
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) dType <= DT_BYTE;
        else     dType <= dTypeNext;
    end

endmodule

`default_nettype wire

// ==== source/riscvIsaPkg.sv ====
`default_nettype none

`include "decode_defines.svh"

// encoding side of the ISA with nothing decoder specific in it
package riscvIsaPkg;

    // --------------------------------------------------
    // raw fields
    // --------------------------------------------------
    typedef logic [`XLEN-1:0] instrWord_t; // full instruction from fetch

    typedef logic [`OPCODE_W-1:0] opcode_t; // bits 6:0
    typedef logic [`FUNCT3_W-1:0] funct3_t; // bits 14:12
    typedef logic [`FUNCT7_W-1:0] funct7_t; // bits 31:25

    // --------------------------------------------------
    // rv32i base major opcodes
    // --------------------------------------------------
    // low two bits are always 11 for 32-bit encodings
    typedef enum logic [`OPCODE_W-1:0] {
        OPC_LOAD   = 7'b0000011, // lb lh lw lbu lhu
        OPC_OPIMM  = 7'b0010011, // addi slti ... srai
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011, // sb sh sw
        OPC_OP     = 7'b0110011, // reg-reg alu
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011, // beq ... bgeu
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } majorOpcode_e;

    // funct3 meanings depend on the opcode, so they are
    // decoded per unit and not listed here
    //
    // funct7 only matters for
    //   add/sub under OP
    //   srl/sra under OP and OPIMM
    // 0x00 is the base form, 0x20 the alternate

    // system, fence and the float/atomic major opcodes
    // are not part of this set and fall through as unknown

endpackage

`default_nettype wire
